// ==== cpuCore.f ====
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/decodeUnit.sv
source/regFile.sv
source/hazardUnit.sv
source/executeUnit.sv
source/cpuCore.sv
verif/cpuCoreChecker.sv
verif/cpuCoreTb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := cpuCoreTb
FILELIST  := cpuCore.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verif/cpuCoreTb.sv ====
`default_nettype none

`include "cpuConsts.svh"

module cpuCoreTb;
	import isaPkg::*;
	import pipePkg::*;

	logic             clk;
	logic             rst;
	logic [`XLEN-1:0] instrAddr;
	logic [`XLEN-1:0] instr;
	busReq_t          dataBus;
	logic [`XLEN-1:0] rdData;

	logic [31:0] rom [256];
	logic [31:0] dmem [256];
	logic [31:0] initImage [256];
	logic [31:0] refMem [256];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] lcgState;
	string       testName;

	cpuCore cpuCore_inst (
		.clk       (clk),
		.rst       (rst),
		.instrAddr (instrAddr),
		.instr     (instr),
		.dataBus   (dataBus),
		.rdData    (rdData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory models indexed by address bits 9:2
	assign instr = rom[instrAddr[9:2]];
	assign rdData = dmem[dataBus.addr[9:2]];

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= initImage[i];
		end else if (dataBus.we) begin
			dmem[dataBus.addr[9:2]] <= dataBus.wData;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 8;
	endfunction

	function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
			funct_e fn);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(opcode_e op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic failRun(string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
			failRun("value mismatch");
		end
	endtask

	// ==================================================================
	// Reference interpreter with one branch delay slot
	// ==================================================================

	function automatic void interpret(int endIdx);
		logic [31:0] regs [32];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		int          idx;
		int          nextIdx;
		int          target;
		int          steps;
		logic        pending;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			refMem[i] = initImage[i];
		idx = 0;
		target = 0;
		steps = 0;
		pending = 1'b0;
		while (idx != endIdx && steps < 10000) begin
			w = rom[idx];
			a = regs[w[25:21]];
			b = regs[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			addr = a + simm;
			nextIdx = pending ? target : idx + 1;
			pending = 1'b0;
			case (w[31:26])
				OP_SPECIAL: begin
					if (w[5:0] == FN_ADDU)
						regs[w[15:11]] = a + b;
					else if (w[5:0] == FN_SUBU)
						regs[w[15:11]] = a - b;
				end
				OP_ORI: regs[w[20:16]] = a | {16'h0, w[15:0]};
				OP_LUI: regs[w[20:16]] = {w[15:0], 16'h0};
				OP_LW:  regs[w[20:16]] = refMem[addr[9:2]];
				OP_SW: begin
					refMem[addr[9:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				OP_BEQ: begin
					if (a == b) begin
						pending = 1'b1;
						target = idx + 1 + int'($signed(w[15:0]));
					end
				end
				default: ;
			endcase
			regs[0] = '0;
			idx = nextIdx;
			steps++;
		end
	endfunction

	// Each bus write against the next expected store
	always @(posedge clk) begin
		if (!rst && dataBus.we) begin
			if (expAddr.size() == 0) begin
				failRun("core wrote to the bus when no store was expected");
			end else begin
				checkValue(testName, {expAddr[0], expData[0]}, {dataBus.addr, dataBus.wData});
				void'(expAddr.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	task automatic clearRom();
		for (int i = 0; i < 256; i++)
			rom[i] = '0;
	endtask

	task automatic runTest(string name, int len);
		int cycles;
		int limit;
		testName = name;
		// Self loop and its NOP delay slot
		rom[len] = encI(OP_BEQ, 5'd0, 5'd0, 16'hffff);
		rom[len + 1] = '0;
		for (int i = 0; i < 256; i++)
			initImage[i] = nextRand() ^ i;
		interpret(len);
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkValue({name, " reset pc"}, {32'h0, `RESET_PC}, {32'h0, instrAddr});
		checkValue({name, " reset we"}, 64'h0, {63'h0, dataBus.we});
		cycles = 0;
		limit = 4 * (len + 2) + 100;
		while (expAddr.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
				failRun("timeout: core stopped producing stores");
		end
	endtask

	// ==================================================================
	// Test programs
	// ==================================================================

	task automatic genRandom(int len);
		logic [31:0] r;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		int          kind;
		logic        prevBranch;
		prevBranch = 1'b0;
		for (int i = 0; i < len; i++) begin
			r = nextRand();
			kind = int'(r % 32'd6);
			rs = {2'b00, r[10:8]};
			rt = {2'b00, r[13:11]};
			rd = {2'b00, r[16:14]};
			// Only forward branches and none in a delay slot
			if (kind == 5 && (prevBranch || i > len - 4))
				kind = 0;
			r = nextRand();
			case (kind)
				0: rom[i] = encR(rs, rt, rd, r[0] ? FN_SUBU : FN_ADDU);
				1: rom[i] = encI(OP_ORI, rs, rt, r[15:0]);
				2: rom[i] = encI(OP_LUI, 5'd0, rt, r[15:0]);
				3: rom[i] = encI(OP_LW, rs, rt, {8'h0, r[5:0], 2'b00});
				4: rom[i] = encI(OP_SW, rs, rt, {8'h0, r[5:0], 2'b00});
				default: rom[i] = encI(OP_BEQ, rs, rt, 16'(1 + int'(r % 32'd3)));
			endcase
			prevBranch = (kind == 5);
		end
	endtask

	initial begin
		rst <= 1'b1;
		lcgState = 32'd18686;
		clearRom();

		rom[0] = encI(OP_ORI, 5'd0, 5'd1, 16'h1234);
		rom[1] = encI(OP_SW, 5'd0, 5'd1, 16'd0);
		rom[2] = encI(OP_LUI, 5'd0, 5'd2, 16'habcd);
		rom[3] = encI(OP_SW, 5'd0, 5'd2, 16'd4);
		rom[4] = encR(5'd1, 5'd2, 5'd3, FN_ADDU);
		rom[5] = encI(OP_SW, 5'd0, 5'd3, 16'd8);
		rom[6] = encR(5'd3, 5'd1, 5'd4, FN_SUBU);
		rom[7] = encI(OP_SW, 5'd0, 5'd4, 16'd12);
		rom[8] = encI(OP_ORI, 5'd4, 5'd5, 16'h00ff);
		rom[9] = encI(OP_SW, 5'd0, 5'd5, 16'd16);
		runTest("dependent alu chain", 10);

		clearRom();
		rom[0] = encI(OP_LW, 5'd0, 5'd6, 16'd32);
		rom[1] = encR(5'd6, 5'd6, 5'd7, FN_ADDU);
		rom[2] = encI(OP_SW, 5'd0, 5'd7, 16'd36);
		runTest("load use", 3);

		clearRom();
		rom[0] = encI(OP_ORI, 5'd0, 5'd1, 16'd5);
		rom[1] = encI(OP_ORI, 5'd0, 5'd2, 16'd5);
		rom[2] = encI(OP_BEQ, 5'd1, 5'd2, 16'd2);
		rom[3] = encI(OP_SW, 5'd0, 5'd1, 16'd0);
		rom[4] = encI(OP_SW, 5'd0, 5'd2, 16'd4);
		rom[5] = encI(OP_ORI, 5'd0, 5'd3, 16'd7);
		rom[6] = encI(OP_BEQ, 5'd3, 5'd1, 16'd1);
		rom[7] = encI(OP_SW, 5'd0, 5'd3, 16'd12);
		rom[8] = encI(OP_SW, 5'd0, 5'd3, 16'd16);
		rom[9] = encI(OP_LW, 5'd0, 5'd4, 16'd12);
		rom[10] = encI(OP_BEQ, 5'd4, 5'd3, 16'd1);
		rom[11] = encI(OP_SW, 5'd0, 5'd4, 16'd20);
		rom[12] = encI(OP_SW, 5'd0, 5'd4, 16'd24);
		rom[13] = encI(OP_SW, 5'd0, 5'd1, 16'd28);
		runTest("branches", 14);

		clearRom();
		rom[0] = encI(OP_ORI, 5'd0, 5'd1, 16'h0033);
		rom[1] = encI(OP_ORI, 5'd0, 5'd0, 16'h0055);
		rom[2] = encR(5'd1, 5'd1, 5'd0, FN_ADDU);
		rom[3] = encI(OP_SW, 5'd0, 5'd0, 16'd0);
		rom[4] = encI(OP_LW, 5'd0, 5'd0, 16'd8);
		rom[5] = encI(OP_SW, 5'd1, 5'd0, 16'd4);
		runTest("register zero", 6);

		clearRom();
		genRandom(200);
		runTest("random program", 200);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/cpuCoreChecker.sv ====
`default_nettype none

`include "cpuConsts.svh"

module cpuCoreChecker (
	input logic              clk,
	input logic              rst,
	input logic [`XLEN-1:0]  instrAddr,
	input pipePkg::busReq_t  dataBus,
	input logic              stall
);
	import pipePkg::*;

	// Bus write enable is always driven
	weKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(dataBus.we))
		else $error("write enable unknown");

	// Fetch is word aligned
	fetchAligned: assert property (@(posedge clk) disable iff (rst) instrAddr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	// PC holds across a stall
	stallHoldsPc: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(instrAddr))
		else $error("fetch address moved during stall");

	// Pipeline is empty right after reset
	noWriteAfterReset: assert property (@(posedge clk) $fell(rst) |-> !dataBus.we)
		else $error("bus write right after reset");

endmodule

bind cpuCore cpuCoreChecker cpuCoreChecker_inst (
	.clk       (clk),
	.rst       (rst),
	.instrAddr (instrAddr),
	.dataBus   (dataBus),
	.stall     (stall)
);

`default_nettype wire

// ==== source/cpuCore.sv ====
`default_nettype none

`include "cpuConsts.svh"

module cpuCore (
	input  logic              clk,
	input  logic              rst,
	output logic [`XLEN-1:0]  instrAddr,
	input  logic [`XLEN-1:0]  instr,
	output pipePkg::busReq_t  dataBus,
	input  logic [`XLEN-1:0]  rdData
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] nextPc;
	logic [`XLEN-1:0] branchTarget;
	logic             branchTaken;
	logic [`XLEN-1:0] instrD;
	instrFields_t     fieldsD;
	ctrl_t            ctrlD;
	logic [`XLEN-1:0] extImmD;
	logic [`XLEN-1:0] rDataA;
	logic [`XLEN-1:0] rDataB;
	logic [`XLEN-1:0] rsValD;
	logic [`XLEN-1:0] rtValD;
	logic             stall;
	logic             fwdDecRs;
	logic             fwdDecRt;
	fwdSel_e          fwdExRs;
	fwdSel_e          fwdExRt;
	decExReg_t        decEx;
	logic [`XLEN-1:0] aluResultE;
	logic [`XLEN-1:0] storeDataE;
	exMemReg_t        exMem;
	logic [`XLEN-1:0] wrDataM;
	memWbReg_t        memWb;

	// ==================================================================
	// Fetch
	// ==================================================================

	// Fetch PC is the delay slot address, i.e. branch PC + 4
	assign branchTarget = pc + (extImmD << 2);
	assign branchTaken = ctrlD.isBranch && (rsValD == rtValD);
	assign nextPc = branchTaken ? branchTarget : pc + `XLEN'd4;
	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			instrD <= '0;
		end else if (!stall) begin
			pc <= nextPc;
			instrD <= instr;
		end
	end

	// ==================================================================
	// Decode
	// ==================================================================

	decodeUnit decodeUnit_inst (
		.instr  (instrD),
		.fields (fieldsD),
		.ctrl   (ctrlD),
		.extImm (extImmD)
	);

	regFile regFile_inst (
		.clk    (clk),
		.rst    (rst),
		.rAddrA (fieldsD.rs),
		.rAddrB (fieldsD.rt),
		.rDataA (rDataA),
		.rDataB (rDataB),
		.wEn    (memWb.ctrl.regWrite),
		.wAddr  (memWb.ctrl.destReg),
		.wData  (memWb.wrData)
	);

	hazardUnit hazardUnit_inst (
		.decCtrl  (ctrlD),
		.decRs    (fieldsD.rs),
		.decRt    (fieldsD.rt),
		.exCtrl   (decEx.ctrl),
		.exRs     (decEx.rs),
		.exRt     (decEx.rt),
		.memCtrl  (exMem.ctrl),
		.wbCtrl   (memWb.ctrl),
		.stall    (stall),
		.fwdDecRs (fwdDecRs),
		.fwdDecRt (fwdDecRt),
		.fwdExRs  (fwdExRs),
		.fwdExRt  (fwdExRt)
	);

	// Memory stage ALU result into decode
	assign rsValD = fwdDecRs ? exMem.aluResult : rDataA;
	assign rtValD = fwdDecRt ? exMem.aluResult : rDataB;

	always_ff @(posedge clk) begin
		decEx.rs <= fieldsD.rs;
		decEx.rt <= fieldsD.rt;
		decEx.rsVal <= rsValD;
		decEx.rtVal <= rtValD;
		decEx.extImm <= extImmD;
		// Bubble into execute while decode is held
		if (rst || stall)
			decEx.ctrl <= '0;
		else
			decEx.ctrl <= ctrlD;
	end

	// ==================================================================
	// Execute
	// ==================================================================

	executeUnit executeUnit_inst (
		.exReg     (decEx),
		.fwdRs     (fwdExRs),
		.fwdRt     (fwdExRt),
		.memResult (exMem.aluResult),
		.wbResult  (memWb.wrData),
		.aluResult (aluResultE),
		.storeData (storeDataE)
	);

	always_ff @(posedge clk) begin
		exMem.aluResult <= aluResultE;
		exMem.storeData <= storeDataE;
		if (rst)
			exMem.ctrl <= '0;
		else
			exMem.ctrl <= decEx.ctrl;
	end

	// ==================================================================
	// Memory and writeback
	// ==================================================================

	assign dataBus.addr = exMem.aluResult;
	assign dataBus.wData = exMem.storeData;
	assign dataBus.we = exMem.ctrl.memWrite;

	assign wrDataM = exMem.ctrl.memRead ? rdData : exMem.aluResult;

	always_ff @(posedge clk) begin
		memWb.wrData <= wrDataM;
		if (rst)
			memWb.ctrl <= '0;
		else
			memWb.ctrl <= exMem.ctrl;
	end

endmodule

`default_nettype wire

// ==== source/executeUnit.sv ====
`default_nettype none

`include "cpuConsts.svh"

module executeUnit (
	input  pipePkg::decExReg_t exReg,
	input  pipePkg::fwdSel_e   fwdRs,
	input  pipePkg::fwdSel_e   fwdRt,
	input  logic [`XLEN-1:0]   memResult,
	input  logic [`XLEN-1:0]   wbResult,
	output logic [`XLEN-1:0]   aluResult,
	output logic [`XLEN-1:0]   storeData
);
	import pipePkg::*;

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] rtVal;
	logic [`XLEN-1:0] opB;

	function automatic logic [`XLEN-1:0] applyFwd(fwdSel_e sel, logic [`XLEN-1:0] regVal,
			logic [`XLEN-1:0] memVal, logic [`XLEN-1:0] wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = applyFwd(fwdRs, exReg.rsVal, memResult, wbResult);
	assign rtVal = applyFwd(fwdRt, exReg.rtVal, memResult, wbResult);
	assign opB = exReg.ctrl.useImm ? exReg.extImm : rtVal;

	// Store data is rt after forwarding
	assign storeData = rtVal;

	always_comb begin
		case (exReg.ctrl.aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_OR:  aluResult = opA | opB;
			ALU_LUI: aluResult = opB << `IMM_W;
			default: aluResult = opA + opB;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

`include "cpuConsts.svh"

module hazardUnit (
	input  pipePkg::ctrl_t         decCtrl,
	input  logic [`REG_ADDR_W-1:0] decRs,
	input  logic [`REG_ADDR_W-1:0] decRt,
	input  pipePkg::ctrl_t         exCtrl,
	input  logic [`REG_ADDR_W-1:0] exRs,
	input  logic [`REG_ADDR_W-1:0] exRt,
	input  pipePkg::ctrl_t         memCtrl,
	input  pipePkg::ctrl_t         wbCtrl,
	output logic                   stall,
	output logic                   fwdDecRs,
	output logic                   fwdDecRt,
	output pipePkg::fwdSel_e       fwdExRs,
	output pipePkg::fwdSel_e       fwdExRt
);
	import pipePkg::*;

	logic decNeedsEx;
	logic decNeedsMem;

	// True when prod writes regNum, register 0 excluded
	function automatic logic writes(ctrl_t prod, logic [`REG_ADDR_W-1:0] regNum);
		return prod.regWrite && (prod.destReg != '0) && (prod.destReg == regNum);
	endfunction

	// Youngest producer wins
	function automatic fwdSel_e pickFwd(logic reads, logic [`REG_ADDR_W-1:0] regNum,
			ctrl_t memProd, ctrl_t wbProd);
		fwdSel_e sel;
		sel = FWD_NONE;
		if (reads && writes(memProd, regNum))
			sel = FWD_MEM;
		else if (reads && writes(wbProd, regNum))
			sel = FWD_WB;
		return sel;
	endfunction

	// ==================================================================
	// Stall detection
	// ==================================================================

	assign decNeedsEx = (decCtrl.readsRs && writes(exCtrl, decRs)) ||
		(decCtrl.readsRt && writes(exCtrl, decRt));
	assign decNeedsMem = (decCtrl.readsRs && writes(memCtrl, decRs)) ||
		(decCtrl.readsRt && writes(memCtrl, decRt));

	// Branch on an execute result, load-use, branch on a load in memory
	assign stall = (decNeedsEx && decCtrl.isBranch) ||
		(decNeedsEx && exCtrl.memRead) ||
		(decNeedsMem && decCtrl.isBranch && memCtrl.memRead);

	// ==================================================================
	// Forward selects
	// ==================================================================

	// Load data is not ready in memory stage for decode
	assign fwdDecRs = writes(memCtrl, decRs) && !memCtrl.memRead;
	assign fwdDecRt = writes(memCtrl, decRt) && !memCtrl.memRead;

	assign fwdExRs = pickFwd(exCtrl.readsRs, exRs, memCtrl, wbCtrl);
	assign fwdExRt = pickFwd(exCtrl.readsRt, exRt, memCtrl, wbCtrl);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none

`include "cpuConsts.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`REG_ADDR_W-1:0] rAddrA,
	input  logic [`REG_ADDR_W-1:0] rAddrB,
	output logic [`XLEN-1:0]       rDataA,
	output logic [`XLEN-1:0]       rDataB,
	input  logic                   wEn,
	input  logic [`REG_ADDR_W-1:0] wAddr,
	input  logic [`XLEN-1:0]       wData
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic             wValid;

	// Register 0 never takes a write
	assign wValid = wEn && (wAddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wValid) begin
			regs[wAddr] <= wData;
		end
	end

	// Write-through gives decode the writeback result in the same cycle
	assign rDataA = (wValid && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (wValid && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

`default_nettype wire

// ==== source/decodeUnit.sv ====
`default_nettype none

`include "cpuConsts.svh"

module decodeUnit (
	input  logic [`XLEN-1:0]     instr,
	output isaPkg::instrFields_t fields,
	output pipePkg::ctrl_t       ctrl,
	output logic [`XLEN-1:0]     extImm
);
	import isaPkg::*;
	import pipePkg::*;

	funct_e funct;

	always_comb begin
		fields.opcode = opcode_e'(instr[`OPCODE_HI:`OPCODE_LO]);
		fields.rs = instr[`RS_HI:`RS_LO];
		fields.rt = instr[`RT_HI:`RT_LO];
		fields.rd = instr[`RD_HI:`RD_LO];
		fields.imm16 = instr[`IMM_W-1:0];
		funct = funct_e'(fields.imm16[5:0]);

		// Default is a bubble, anything unknown stays that way
		ctrl = '0;
		case (fields.opcode)
			OP_SPECIAL: begin
				if (funct == FN_ADDU || funct == FN_SUBU) begin
					ctrl.regWrite = 1'b1;
					ctrl.readsRs = 1'b1;
					ctrl.readsRt = 1'b1;
					ctrl.aluOp = (funct == FN_SUBU) ? ALU_SUB : ALU_ADD;
					ctrl.destReg = fields.rd;
				end
			end
			OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.readsRs = 1'b1;
				ctrl.aluOp = ALU_OR;
				ctrl.destReg = fields.rt;
			end
			OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.aluOp = ALU_LUI;
				ctrl.destReg = fields.rt;
			end
			OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.readsRs = 1'b1;
				ctrl.destReg = fields.rt;
			end
			// Stores and branches keep destReg at zero
			OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.readsRs = 1'b1;
				ctrl.readsRt = 1'b1;
			end
			OP_BEQ: begin
				ctrl.isBranch = 1'b1;
				ctrl.readsRs = 1'b1;
				ctrl.readsRt = 1'b1;
			end
			default: ;
		endcase

		if (ctrl.zeroExt)
			extImm = {{(`XLEN-`IMM_W){1'b0}}, fields.imm16};
		else
			extImm = {{(`XLEN-`IMM_W){fields.imm16[`IMM_W-1]}}, fields.imm16};
	end

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
`default_nettype none

`include "cpuConsts.svh"

package pipePkg;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_LUI
	} aluOp_e;

	// Operand source for execute, memory stage is the younger producer
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwdSel_e;

	// All zero is a bubble
	typedef struct packed {
		logic                    regWrite;
		logic                    memRead;
		logic                    memWrite;
		logic                    isBranch;
		logic                    useImm;
		logic                    zeroExt;
		aluOp_e                  aluOp;
		logic [`REG_ADDR_W-1:0]  destReg;
		logic                    readsRs;
		logic                    readsRt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`REG_ADDR_W-1:0]  rs;
		logic [`REG_ADDR_W-1:0]  rt;
		logic [`XLEN-1:0]        rsVal;
		logic [`XLEN-1:0]        rtVal;
		logic [`XLEN-1:0]        extImm;
	} decExReg_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [`XLEN-1:0]  aluResult;
		logic [`XLEN-1:0]  storeData;
	} exMemReg_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [`XLEN-1:0]  wrData;
	} memWbReg_t;

	// Single-cycle data bus, no handshake
	typedef struct packed {
		logic [`XLEN-1:0]  addr;
		logic [`XLEN-1:0]  wData;
		logic              we;
	} busReq_t;

endpackage

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

`include "cpuConsts.svh"

package isaPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// Function codes under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23
	} funct_e;

	// Raw instruction fields, rd overlaps the top of imm16
	typedef struct packed {
		opcode_e                 opcode;
		logic [`REG_ADDR_W-1:0]  rs;
		logic [`REG_ADDR_W-1:0]  rt;
		logic [`REG_ADDR_W-1:0]  rd;
		logic [`IMM_W-1:0]       imm16;
	} instrFields_t;

endpackage

`default_nettype wire

// ==== source/cpuConsts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address out of reset
`define RESET_PC 32'h0000_3000

// Instruction word field positions
`define OPCODE_HI 31
`define OPCODE_LO 26
`define RS_HI 25
`define RS_LO 21
`define RT_HI 20
`define RT_LO 16
`define RD_HI 15
`define RD_LO 11

// Low half of I-type words
`define IMM_W 16

`endif
